//--- Makefile
SIM       := verilator
TOP       := issue_core_tb
FILELIST  := issue_core.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/issue_pkg.sv
package issue_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [xlen-1:0] pc_t;

  typedef enum logic [6:0] {
    op_reg = 7'b0110011,
    op_imm = 7'b0010011,
    op_lui = 7'b0110111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    id_idle,
    id_wait,
    id_hazard
  } id_state_e;

  typedef struct packed {
    pc_t pc;
    word_t instr;
  } fetch_t;

  typedef struct packed {
    alu_op_e alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic use_rs1;
    logic use_rs2;
    logic use_imm;
    logic writes_rd;
    word_t imm;
    logic illegal;
  } decoded_t;

  typedef struct packed {
    alu_op_e alu_op;
    reg_addr_t rd;
    logic writes_rd;
    word_t operand_a;
    word_t operand_b;
    pc_t pc;
  } issue_t;

  typedef struct packed {
    logic valid;
    reg_addr_t rd;
    word_t data;
    pc_t pc;
  } writeback_t;

endpackage

//--- dv/issue_core_assert.sv
`timescale 1ns/100ps

module issue_core_assert (
  input logic clock,
  input logic reset,
  input logic fetch_ready,
  input logic issue_valid,
  input logic exu_ready,
  input issue_pkg::issue_t issue,
  input issue_pkg::id_state_e state
);

  logic [1:0] hazard_cycles;

  always_ff @(posedge clock) begin
    if (reset) begin
      hazard_cycles <= '0;
    end else if (state == issue_pkg::id_hazard) begin
      if (hazard_cycles != 2'd3) begin
        hazard_cycles <= hazard_cycles + 2'd1; // saturates
      end
    end else begin
      hazard_cycles <= '0;
    end
  end

  reset_low: assert property (@(posedge clock) reset |=> !issue_valid && !fetch_ready)
    else $error("issue_valid or fetch_ready high right after reset");

  no_overlap: assert property (@(posedge clock) disable iff (reset)
    !(fetch_ready && issue_valid))
    else $error("fetch_ready and issue_valid high in the same cycle");

  issue_stable: assert property (@(posedge clock) disable iff (reset)
    issue_valid && !exu_ready |=> $stable(issue))
    else $error("issue payload changed while waiting for exu_ready");

  hazard_bound: assert property (@(posedge clock) disable iff (reset)
    state == issue_pkg::id_hazard |-> hazard_cycles < 2'd3)
    else $error("issue stage stayed in the hazard state longer than 3 cycles");

endmodule

bind issue_stage issue_core_assert i_issue_core_assert (
  .clock       (clock),
  .reset       (reset),
  .fetch_ready (fetch_ready),
  .issue_valid (issue_valid),
  .exu_ready   (exu_ready),
  .issue       (issue),
  .state       (state)
);

//--- dv/issue_core_tb.sv
`timescale 1ns/100ps

module issue_core_tb;

  typedef enum {
    k_add, k_sub, k_and, k_or, k_xor, k_slt,
    k_addi, k_andi, k_ori, k_xori, k_slti, k_lui,
    k_lw, k_beq
  } instr_kind_e;

  localparam int test_instrs = 47;
  localparam int clock_period = 100;
  localparam int drive_delay = 10;

  logic clock;
  logic reset;
  logic fetch_valid;
  issue_pkg::fetch_t fetch;
  logic fetch_ready;
  issue_pkg::writeback_t wb;

  issue_pkg::word_t ref_regs [issue_pkg::reg_count];
  issue_pkg::writeback_t expect_q [$];
  issue_pkg::pc_t next_pc;
  string test_name;
  logic fetch_taken;

  issue_core i_issue_core (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .fetch_ready (fetch_ready),
    .wb          (wb)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  function automatic issue_pkg::word_t encode(input instr_kind_e kind, input int rd,
                                              input int rs1, input int rs2, input int imm);
    logic [4:0] d;
    logic [4:0] s1;
    logic [4:0] s2;
    logic [11:0] i12;
    logic [2:0] f3;
    d = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    i12 = imm[11:0];
    case (kind)
      k_slt, k_slti, k_lw: f3 = 3'b010;
      k_xor, k_xori: f3 = 3'b100;
      k_or, k_ori: f3 = 3'b110;
      k_and, k_andi: f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    case (kind)
      k_add, k_and, k_or, k_xor, k_slt: return {7'b0000000, s2, s1, f3, d, 7'b0110011};
      k_sub: return {7'b0100000, s2, s1, f3, d, 7'b0110011};
      k_lui: return {imm[19:0], d, 7'b0110111};
      k_lw: return {i12, s1, f3, d, 7'b0000011};
      k_beq: return {7'b0000000, s2, s1, f3, d, 7'b1100011}; // branch offset bits arbitrary
      default: return {i12, s1, f3, d, 7'b0010011};
    endcase
  endfunction

  // rv32i semantics of the supported subset
  function automatic issue_pkg::word_t model_result(input instr_kind_e kind,
      input issue_pkg::word_t a, input issue_pkg::word_t b, input int imm);
    issue_pkg::word_t simm;
    simm = {{20{imm[11]}}, imm[11:0]};
    case (kind)
      k_add: return a + b;
      k_sub: return a - b;
      k_and: return a & b;
      k_or: return a | b;
      k_xor: return a ^ b;
      k_slt: return {31'b0, $signed(a) < $signed(b)};
      k_addi: return a + simm;
      k_andi: return a & simm;
      k_ori: return a | simm;
      k_xori: return a ^ simm;
      k_slti: return {31'b0, $signed(a) < $signed(simm)};
      k_lui: return {imm[19:0], 12'b0};
      default: return '0;
    endcase
  endfunction

  task automatic send(input instr_kind_e kind, input int rd, input int rs1, input int rs2,
                      input int imm);
    issue_pkg::reg_addr_t d;
    issue_pkg::reg_addr_t s1;
    issue_pkg::reg_addr_t s2;
    issue_pkg::word_t result;
    issue_pkg::writeback_t entry;
    d = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    result = model_result(kind, ref_regs[s1], ref_regs[s2], imm);
    if (kind != k_lw && kind != k_beq && d != '0) begin
      ref_regs[d] = result;
      entry = '{valid: 1'b1, rd: d, data: result, pc: next_pc};
      expect_q.push_back(entry);
    end
    fetch_valid = 1'b1;
    fetch.pc = next_pc;
    fetch.instr = encode(kind, rd, rs1, rs2, imm);
    do begin
      @(negedge clock);
    end while (!fetch_ready);
    @(posedge clock); // transfer edge
    #(drive_delay);
    fetch_valid = 1'b0;
    next_pc = next_pc + 32'd4;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #(drive_delay);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < 50) begin
      @(posedge clock);
      waited++;
    end
    repeat (5) @(posedge clock); // room for stray writebacks
    #(drive_delay);
  endtask

  task automatic test_immediates();
    test_name = "immediates";
    for (int i = 0; i < 12; i++) begin
      send(instr_kind_e'(int'(k_addi) + i % 6), i + 1, (i < 6) ? 0 : i - 5, 0, $urandom);
    end
    drain();
  endtask

  task automatic test_register_ops();
    test_name = "register_ops";
    send(k_addi, 13, 0, 0, -5);
    send(k_addi, 14, 0, 0, 7);
    send(k_lui, 15, 0, 0, 'h80000); // most negative word
    for (int i = 0; i < 6; i++) begin
      send(instr_kind_e'(int'(k_add) + i), 16 + i, 13 + i % 3, 1 + $urandom_range(11, 0), 0);
    end
    send(k_slt, 22, 13, 14, 0);
    send(k_slt, 23, 14, 13, 0);
    send(k_slt, 24, 15, 13, 0);
    drain();
  endtask

  task automatic test_dependences();
    test_name = "dependences";
    send(k_add, 25, 13, 14, 0);
    send(k_add, 26, 25, 14, 0); // through rs1
    send(k_sub, 27, 14, 26, 0); // through rs2
    send(k_add, 28, 27, 27, 0); // both sources
    send(k_addi, 29, 28, 0, $urandom);
    send(k_slt, 30, 29, 13, 0);
    drain();
  endtask

  task automatic test_x0();
    test_name = "x0";
    send(k_addi, 0, 14, 0, 5); // no writeback
    send(k_add, 30, 0, 14, 0);
    send(k_or, 31, 0, 0, 0);
    drain();
  endtask

  task automatic test_illegal();
    test_name = "illegal";
    send(k_lw, 5, 1, 0, 16);
    send(k_addi, 20, 20, 0, 1);
    send(k_beq, 6, 20, 20, 0);
    send(k_add, 21, 20, 20, 0);
    drain();
  endtask

  task automatic test_fetch_gaps();
    test_name = "fetch_gaps";
    for (int i = 0; i < 10; i++) begin
      idle_cycles($urandom_range(5, 0));
      send(instr_kind_e'(int'(k_add) + $urandom_range(11, 0)), 1 + $urandom_range(30, 0),
           $urandom_range(31, 0), $urandom_range(31, 0), $urandom);
    end
    drain();
  endtask

  // writeback and fetch monitor
  always @(negedge clock) begin
    issue_pkg::writeback_t exp_wb;
    if (!reset) begin
      if (fetch_taken) begin
        assert (!fetch_ready)
          else stop_run("fetch_ready stayed high in the cycle after a fetch transfer");
      end
      fetch_taken = fetch_valid && fetch_ready;
      if (wb.valid) begin
        assert (expect_q.size() > 0)
          else stop_run($sformatf("writeback to x%0d at pc %h that no instruction expects",
                                  wb.rd, wb.pc));
        exp_wb = expect_q.pop_front();
        assert (wb == exp_wb)
          else stop_run($sformatf(
            "error %s: expected rd %0d data %h pc %h, actual rd %0d data %h pc %h",
            test_name, exp_wb.rd, exp_wb.data, exp_wb.pc, wb.rd, wb.data, wb.pc));
      end
    end
  end

  initial begin
    repeat (test_instrs * 200 + 500) @(posedge clock);
    stop_run("timeout because the tests did not finish in time");
  end

  initial begin
    void'($urandom(90076));
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    next_pc = 32'h0000_1000;
    fetch_taken = 1'b0;
    test_name = "reset";
    for (int i = 0; i < issue_pkg::reg_count; i++) begin
      ref_regs[i] = '0;
    end
    repeat (10) @(posedge clock);
    #(drive_delay);
    reset = 1'b0;
    test_immediates();
    test_register_ops();
    test_dependences();
    test_x0();
    test_illegal();
    test_fetch_gaps();
    if (expect_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d expected writebacks never arrived", expect_q.size()));
    end
  end

endmodule

//--- hw/alu_pipe.sv
`timescale 1ns/100ps

module alu_pipe (
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  issue_pkg::issue_t issue,
  output logic exu_ready,
  output issue_pkg::writeback_t wb
);

  logic ready_q;
  logic s1_valid;
  issue_pkg::issue_t s1_op;
  issue_pkg::word_t result;
  logic wb_valid;
  issue_pkg::reg_addr_t wb_rd;
  issue_pkg::word_t wb_data;
  issue_pkg::pc_t wb_pc;

  assign exu_ready = ready_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
      s1_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      ready_q <= 1'b1; // no back-pressure
      s1_valid <= issue_valid && exu_ready;
      wb_valid <= s1_valid && s1_op.writes_rd && (s1_op.rd != '0);
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid && exu_ready) begin
      s1_op <= issue;
    end
    if (s1_valid) begin
      wb_rd <= s1_op.rd;
      wb_data <= result;
      wb_pc <= s1_op.pc;
    end
  end

  // stage two
  always_comb begin
    case (s1_op.alu_op)
      issue_pkg::alu_add: result = s1_op.operand_a + s1_op.operand_b;
      issue_pkg::alu_sub: result = s1_op.operand_a - s1_op.operand_b;
      issue_pkg::alu_and: result = s1_op.operand_a & s1_op.operand_b;
      issue_pkg::alu_or: result = s1_op.operand_a | s1_op.operand_b;
      issue_pkg::alu_xor: result = s1_op.operand_a ^ s1_op.operand_b;
      issue_pkg::alu_slt: begin
        result = {{(issue_pkg::xlen - 1){1'b0}},
                  ($signed(s1_op.operand_a) < $signed(s1_op.operand_b))}; // signed compare
      end
      issue_pkg::alu_pass_b: result = s1_op.operand_b; // lui
      default: result = '0;
    endcase
  end

  assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data, pc: wb_pc};

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
  input  issue_pkg::word_t instr,
  output issue_pkg::decoded_t dec
);

  issue_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = issue_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    dec = '0;
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.rd = instr[11:7];
    dec.alu_op = issue_pkg::alu_add;
    dec.illegal = 1'b1; // cleared by the supported subset
    case (opcode)
      issue_pkg::op_reg: begin
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
        dec.illegal = 1'b0;
        case (funct3)
          3'b000: begin
            if (funct7[5]) begin
              dec.alu_op = issue_pkg::alu_sub;
            end else begin
              dec.alu_op = issue_pkg::alu_add;
            end
          end
          3'b010: dec.alu_op = issue_pkg::alu_slt;
          3'b100: dec.alu_op = issue_pkg::alu_xor;
          3'b110: dec.alu_op = issue_pkg::alu_or;
          3'b111: dec.alu_op = issue_pkg::alu_and;
          default: dec.illegal = 1'b1; // shifts, sltu
        endcase
        if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          dec.illegal = 1'b1; // m extension, sra
        end
      end
      issue_pkg::op_imm: begin
        dec.use_rs1 = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm = {{20{instr[31]}}, instr[31:20]}; // sign-extended i-type
        dec.illegal = 1'b0;
        case (funct3)
          3'b000: dec.alu_op = issue_pkg::alu_add;
          3'b010: dec.alu_op = issue_pkg::alu_slt;
          3'b100: dec.alu_op = issue_pkg::alu_xor;
          3'b110: dec.alu_op = issue_pkg::alu_or;
          3'b111: dec.alu_op = issue_pkg::alu_and;
          default: dec.illegal = 1'b1; // shift immediates
        endcase
      end
      issue_pkg::op_lui: begin
        dec.use_imm = 1'b1;
        dec.imm = {instr[31:12], 12'b0}; // u-type
        dec.alu_op = issue_pkg::alu_pass_b;
        dec.illegal = 1'b0;
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.use_rs1 = 1'b0; // bubble reads nothing
      dec.use_rs2 = 1'b0;
      dec.use_imm = 1'b0;
      dec.alu_op = issue_pkg::alu_add;
    end
    dec.writes_rd = !dec.illegal;
  end

endmodule

//--- hw/issue_core.sv
`timescale 1ns/100ps

module issue_core (
  input  logic clock,
  input  logic reset,
  input  logic fetch_valid,
  input  issue_pkg::fetch_t fetch,
  output logic fetch_ready,
  output issue_pkg::writeback_t wb
);

  issue_pkg::word_t dec_instr;
  issue_pkg::decoded_t dec;
  issue_pkg::reg_addr_t rs1_addr;
  issue_pkg::reg_addr_t rs2_addr;
  issue_pkg::word_t rs1_data;
  issue_pkg::word_t rs2_data;
  logic issue_valid;
  issue_pkg::issue_t issue;
  logic exu_ready;

  issue_stage i_issue_stage (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .fetch_ready (fetch_ready),
    .dec_instr   (dec_instr),
    .dec         (dec),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue_valid (issue_valid),
    .issue       (issue),
    .exu_ready   (exu_ready),
    .wb          (wb)
  );

  instr_decoder i_instr_decoder (
    .instr (dec_instr),
    .dec   (dec)
  );

  reg_file i_reg_file (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  alu_pipe i_alu_pipe (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .exu_ready   (exu_ready),
    .wb          (wb)
  );

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic clock,
  input  logic reset,
  input  issue_pkg::reg_addr_t rs1_addr,
  input  issue_pkg::reg_addr_t rs2_addr,
  output issue_pkg::word_t rs1_data,
  output issue_pkg::word_t rs2_data,
  input  issue_pkg::writeback_t wb
);

  issue_pkg::word_t regs [issue_pkg::reg_count];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < issue_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data; // x0 never written
    end
  end

  // async reads with x0 hardwired
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

//--- issue/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
  input  logic clock,
  input  logic reset,
  input  logic fetch_valid,
  input  issue_pkg::fetch_t fetch,
  output logic fetch_ready,
  output issue_pkg::word_t dec_instr,
  input  issue_pkg::decoded_t dec,
  output issue_pkg::reg_addr_t rs1_addr,
  output issue_pkg::reg_addr_t rs2_addr,
  input  issue_pkg::word_t rs1_data,
  input  issue_pkg::word_t rs2_data,
  output logic issue_valid,
  output issue_pkg::issue_t issue,
  input  logic exu_ready,
  input  issue_pkg::writeback_t wb
);

  issue_pkg::id_state_e state, state_next;
  logic fetch_fire;
  logic issue_fire;
  logic [issue_pkg::reg_count-1:0] pending;
  logic [1:0] wb_hit_d, wb_hit_q;
  logic [1:0] hazard_d, hazard_q, hazard_left;
  issue_pkg::reg_addr_t src1_q, src2_q;
  issue_pkg::word_t operand_a, operand_b;

  assign fetch_fire = fetch_valid && fetch_ready;
  assign issue_fire = issue_valid && exu_ready;

  assign dec_instr = fetch.instr; // decode straight from the fetch port
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  // a source cleared by this cycle's writeback is not a hazard
  assign wb_hit_d[0] = wb.valid && (wb.rd == dec.rs1);
  assign wb_hit_d[1] = wb.valid && (wb.rd == dec.rs2);
  assign hazard_d[0] = dec.use_rs1 && pending[dec.rs1] && !wb_hit_d[0];
  assign hazard_d[1] = dec.use_rs2 && pending[dec.rs2] && !wb_hit_d[1];

  // while stalled, compare against the captured sources
  assign wb_hit_q[0] = wb.valid && (wb.rd == src1_q);
  assign wb_hit_q[1] = wb.valid && (wb.rd == src2_q);
  assign hazard_left = hazard_q & ~wb_hit_q;

  always_comb begin
    operand_a = '0; // lui and bubbles
    if (dec.use_rs1) begin
      operand_a = wb_hit_d[0] ? wb.data : rs1_data;
    end
    if (dec.use_imm) begin
      operand_b = dec.imm;
    end else begin
      operand_b = wb_hit_d[1] ? wb.data : rs2_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= issue_pkg::id_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      issue_pkg::id_idle: begin
        if (fetch_fire) begin
          state_next = (|hazard_d) ? issue_pkg::id_hazard : issue_pkg::id_wait;
        end
      end
      issue_pkg::id_wait: begin
        if (issue_fire) begin
          state_next = issue_pkg::id_idle;
        end
      end
      issue_pkg::id_hazard: begin
        if (hazard_left == 2'b00) begin
          state_next = issue_pkg::id_wait;
        end
      end
      default: state_next = issue_pkg::id_idle;
    endcase
  end

  // registered handshakes
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_ready <= 1'b0;
      issue_valid <= 1'b0;
      hazard_q <= 2'b00;
    end else begin
      case (state)
        issue_pkg::id_idle: begin
          fetch_ready <= !fetch_fire;
          issue_valid <= fetch_fire && !(|hazard_d);
          if (fetch_fire) begin
            hazard_q <= hazard_d;
          end
        end
        issue_pkg::id_wait: begin
          fetch_ready <= issue_fire;
          issue_valid <= !issue_fire;
        end
        issue_pkg::id_hazard: begin
          fetch_ready <= 1'b0;
          issue_valid <= (hazard_left == 2'b00);
          hazard_q <= hazard_left; // flags clear independently
        end
        default: begin
          fetch_ready <= 1'b0;
          issue_valid <= 1'b0;
          hazard_q <= 2'b00;
        end
      endcase
    end
  end

  // operand capture and forwarding
  always_ff @(posedge clock) begin
    if (state == issue_pkg::id_idle && fetch_fire) begin
      issue.alu_op <= dec.alu_op;
      issue.rd <= dec.rd;
      issue.writes_rd <= dec.writes_rd;
      issue.operand_a <= operand_a;
      issue.operand_b <= operand_b;
      issue.pc <= fetch.pc;
      src1_q <= dec.rs1;
      src2_q <= dec.rs2;
    end else if (state == issue_pkg::id_hazard) begin
      if (hazard_q[0] && wb_hit_q[0]) begin
        issue.operand_a <= wb.data;
      end
      if (hazard_q[1] && wb_hit_q[1]) begin
        issue.operand_b <= wb.data;
      end
    end
  end

  scoreboard i_scoreboard (
    .clock   (clock),
    .reset   (reset),
    .set_en  (issue_fire && issue.writes_rd),
    .set_rd  (issue.rd),
    .clear   (wb),
    .pending (pending)
  );

endmodule

//--- issue/scoreboard.sv
`timescale 1ns/100ps

module scoreboard (
  input  logic clock,
  input  logic reset,
  input  logic set_en,
  input  issue_pkg::reg_addr_t set_rd,
  input  issue_pkg::writeback_t clear,
  output logic [issue_pkg::reg_count-1:0] pending
);

  logic [issue_pkg::reg_count-1:0] pending_next;

  always_comb begin
    pending_next = pending;
    if (clear.valid) begin
      pending_next[clear.rd] = 1'b0;
    end
    // set wins as it belongs to the newer instruction
    if (set_en && set_rd != '0) begin
      pending_next[set_rd] = 1'b1;
    end
    pending_next[0] = 1'b0; // x0 never pending
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

endmodule

//--- issue_core.f
common/issue_pkg.sv
issue/scoreboard.sv
issue/issue_stage.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu_pipe.sv
hw/issue_core.sv
dv/issue_core_assert.sv
dv/issue_core_tb.sv
